// ==== flist.f ====
+incdir+include
verilog/spi_host_pkg.sv
verilog/apb_spi_regs.sv
verilog/spi_shifter.sv
verilog/spi_host_top.sv
testbench/tb_spi_host.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_spi_host

out=$(./obj_dir/Vtb_spi_host)
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
	exit 0
else
	exit 1
fi

// ==== testbench/tb_spi_host.sv ====
`timescale 1ns/10ps
`include "spi_host_cfg.svh"

module tb_spi_host;

	////////////////////////////////////////
	// Run length

	// Two back-to-back plus forty random transfers
	localparam int N_XFER = 42;
	// Worst case divider 8 times 16 half periods times 40 ns
	localparam int WATCHDOG_NS = N_XFER * 16 * 8 * 40 + 200000;

	logic apb;
	logic reset;
	spi_host_pkg::apb_req_t apb_req;
	spi_host_pkg::apb_rsp_t apb_rsp;
	logic spi_sck;
	logic spi_mosi;
	logic spi_miso = 1'b0;
	logic spi_cs_n;

	int errors = 0;
	int checks = 0;
	logic [31:0] lfsr_state = 32'he9d9;
	// Divider of the transfer in flight for SCK timing
	int cur_div = 1;

	// Bytes seen by the device model, in order
	logic [7:0] mosi_q[$];
	logic [7:0] reply_q[$];

	spi_host_top dut0 (
		.apb(apb),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.spi_sck(spi_sck),
		.spi_mosi(spi_mosi),
		.spi_miso(spi_miso),
		.spi_cs_n(spi_cs_n)
	);

	initial begin
		apb = 1'b0;
		forever #20 apb = ~apb;
	end

	////////////////////////////////////////
	// Random numbers and checks

	// Galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [7:0] rand_unmapped();
		logic [7:0] a;
		a = 8'(rand_bits(8));
		while (a == `SPI_REG_CLK_DIV || a == `SPI_REG_DATA || a == `SPI_REG_CS_N ||
				a == `SPI_REG_STATUS)
			a = 8'(rand_bits(8));
		return a;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0d ns: %s, got 0x%0h, expected 0x%0h",
				$time, what, got, exp);
		end
	endtask

	////////////////////////////////////////
	// APB driver

	// Setup then access held until pready
	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [15:0] wdata,
			output logic [15:0] rdata, output logic err, output int waits);
		waits = 0;
		@(negedge apb);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = wr;
		apb_req.paddr = addr;
		apb_req.pwdata = wdata;
		@(negedge apb);
		apb_req.penable = 1'b1;
		// Response settled by mid cycle
		#1;
		while (!apb_rsp.pready) begin
			waits++;
			@(negedge apb);
			#1;
		end
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		// Completed on the rising edge in between
		@(negedge apb);
		apb_req.psel = 1'b0;
		apb_req.penable = 1'b0;
		apb_req.pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [15:0] wdata, output logic err);
		logic [15:0] rdata;
		int waits;
		apb_access(1'b1, addr, wdata, rdata, err, waits);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [15:0] rdata, output logic err);
		int waits;
		apb_access(1'b0, addr, 16'h0000, rdata, err, waits);
	endtask

	// Poll STATUS until busy drops
	task automatic wait_idle();
		logic [15:0] d;
		logic e;
		d = 16'h0001;
		while (d[0])
			apb_read(`SPI_REG_STATUS, d, e);
	endtask

	// Oldest byte from the device model against what was sent
	task automatic pop_transfer(input logic [7:0] tx, output logic [7:0] reply);
		if (mosi_q.size() == 0 || reply_q.size() == 0) begin
			errors++;
			$display("Device model received no byte at %0d ns", $time);
			reply = 8'h00;
		end else begin
			check_value(32'(mosi_q.pop_front()), 32'(tx), "byte captured from MOSI");
			reply = reply_q.pop_front();
		end
	endtask

	////////////////////////////////////////
	// SPI device model in mode 0

	logic prev_sck = 1'b0;
	logic prev_cs = 1'b1;
	logic reload = 1'b0;
	logic [7:0] reply_byte = 8'h00;
	logic [7:0] miso_sr = 8'h00;
	logic [7:0] mosi_byte = 8'h00;
	int rise_cnt = 0;
	time last_edge_t = 0;

	always @(negedge apb) begin
		if (!reset) begin
			// Fresh reply on select
			if (prev_cs && !spi_cs_n) begin
				reply_byte = 8'(rand_bits(8));
				miso_sr = reply_byte;
				spi_miso = miso_sr[7];
				rise_cnt = 0;
			end

			if (spi_sck && !prev_sck) begin
				// Rising SCK ends the low phase
				if (rise_cnt != 0)
					check_value(32'($time - last_edge_t), 32'(cur_div * 40), "SCK low time");
				last_edge_t = $time;
				mosi_byte = {mosi_byte[6:0], spi_mosi};
				rise_cnt++;
				if (rise_cnt == 8) begin
					mosi_q.push_back(mosi_byte);
					reply_q.push_back(reply_byte);
					rise_cnt = 0;
					reload = 1'b1;
				end
			end else if (!spi_sck && prev_sck) begin
				check_value(32'($time - last_edge_t), 32'(cur_div * 40), "SCK high time");
				last_edge_t = $time;
				// Next reply loaded before the next rise
				if (reload) begin
					reply_byte = 8'(rand_bits(8));
					miso_sr = reply_byte;
					reload = 1'b0;
				end else begin
					miso_sr = {miso_sr[6:0], 1'b0};
				end
				spi_miso = miso_sr[7];
			end

			prev_sck = spi_sck;
			prev_cs = spi_cs_n;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the run timed out before all tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	////////////////////////////////////////
	// Test sequence

	initial begin
		logic [15:0] rd;
		logic err;
		int waits;
		logic [15:0] wd;
		logic [15:0] exp_div;
		logic [7:0] tx_a;
		logic [7:0] tx_b;
		logic [7:0] r_a;
		logic [7:0] r_b;

		reset = 1'b1;
		apb_req = '0;
		repeat (10) @(negedge apb);
		reset = 1'b0;

		// Reset values
		apb_read(`SPI_REG_CLK_DIV, rd, err);
		check_value(32'(rd), 32'(`SPI_CLK_DIV_RESET), "CLK_DIV after reset");
		check_value(32'(err), 0, "pslverr on CLK_DIV read");
		apb_read(`SPI_REG_CS_N, rd, err);
		check_value(32'(rd), 1, "CS_N after reset");
		apb_read(`SPI_REG_STATUS, rd, err);
		check_value(32'(rd), 0, "STATUS after reset");
		apb_read(`SPI_REG_DATA, rd, err);
		check_value(32'(rd), 0, "DATA after reset");
		check_value(32'(spi_cs_n), 1, "spi_cs_n after reset");
		exp_div = `SPI_CLK_DIV_RESET;

		// Divider and chip select readback
		for (int i = 0; i < 8; i++) begin
			wd = 16'(rand_bits(16));
			if (wd == 16'h0000)
				wd = 16'h0001;
			apb_write(`SPI_REG_CLK_DIV, wd, err);
			check_value(32'(err), 0, "pslverr on CLK_DIV write");
			apb_read(`SPI_REG_CLK_DIV, rd, err);
			check_value(32'(rd), 32'(wd), "CLK_DIV readback");
			exp_div = wd;

			// Upper bits ignored
			wd = 16'(rand_bits(16));
			apb_write(`SPI_REG_CS_N, wd, err);
			check_value(32'(err), 0, "pslverr on CS_N write");
			apb_read(`SPI_REG_CS_N, rd, err);
			check_value(32'(rd), 32'(wd[0]), "CS_N readback");
			check_value(32'(spi_cs_n), 32'(wd[0]), "spi_cs_n pin");
		end

		// Error responses
		for (int i = 0; i < 6; i++) begin
			apb_write(rand_unmapped(), 16'(rand_bits(16)), err);
			check_value(32'(err), 1, "pslverr on unmapped write");
			apb_read(rand_unmapped(), rd, err);
			check_value(32'(err), 1, "pslverr on unmapped read");
			check_value(32'(rd), 0, "prdata on unmapped read");
		end
		apb_write(`SPI_REG_STATUS, 16'h0001, err);
		check_value(32'(err), 1, "pslverr on STATUS write");
		apb_write(`SPI_REG_CLK_DIV, 16'h0000, err);
		check_value(32'(err), 1, "pslverr on zero CLK_DIV write");
		apb_read(`SPI_REG_CLK_DIV, rd, err);
		check_value(32'(rd), 32'(exp_div), "CLK_DIV kept after errors");

		// Random transfers with the device selected throughout
		apb_write(`SPI_REG_CS_N, 16'h0000, err);
		for (int i = 0; i < N_XFER - 2; i++) begin
			cur_div = int'(rand_bits(3)) + 1;
			apb_write(`SPI_REG_CLK_DIV, 16'(cur_div), err);
			tx_a = 8'(rand_bits(8));
			apb_write(`SPI_REG_DATA, {8'h00, tx_a}, err);
			check_value(32'(err), 0, "pslverr on DATA write");
			wait_idle();
			pop_transfer(tx_a, r_a);
			apb_read(`SPI_REG_DATA, rd, err);
			check_value(32'(rd), 32'(r_a), "DATA read after transfer");
		end

		// Second write stalls behind the first
		cur_div = int'(rand_bits(3)) + 1;
		apb_write(`SPI_REG_CLK_DIV, 16'(cur_div), err);
		tx_a = 8'(rand_bits(8));
		tx_b = 8'(rand_bits(8));
		apb_write(`SPI_REG_DATA, {8'h00, tx_a}, err);
		apb_access(1'b1, `SPI_REG_DATA, {8'h00, tx_b}, rd, err, waits);
		check_value(32'(err), 0, "pslverr on stalled DATA write");
		check_value(32'(waits > 0), 1, "wait states on DATA write while busy");
		// First byte already complete at that point
		check_value(32'(mosi_q.size()), 1, "bytes done when stalled write completes");
		apb_read(`SPI_REG_STATUS, rd, err);
		check_value(32'(rd), 1, "STATUS during transfer");
		wait_idle();
		pop_transfer(tx_a, r_a);
		pop_transfer(tx_b, r_b);
		apb_read(`SPI_REG_DATA, rd, err);
		check_value(32'(rd), 32'(r_b), "DATA read after back-to-back");

		$display("Done with %0d errors in %0d checks", errors, checks);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== verilog/spi_host_top.sv ====
`timescale 1ns/10ps

module spi_host_top (
	input logic apb,
	input logic reset,

	// APB completer
	input spi_host_pkg::apb_req_t apb_req,
	output spi_host_pkg::apb_rsp_t apb_rsp,

	// SPI pins
	output logic spi_sck,
	output logic spi_mosi,
	input logic spi_miso,
	output logic spi_cs_n
);

	////////////////////////////////////////
	// Internal links

	spi_host_pkg::shift_req_t shift_req;
	spi_host_pkg::shift_rsp_t shift_rsp;
	logic req_valid;
	logic req_ready;
	logic rsp_valid;
	// Programmed chip select, registered in the pin stage
	logic cs_n;

	// Register file and APB decode
	apb_spi_regs regs0 (
		.apb(apb),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.shift_req(shift_req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.shift_rsp(shift_rsp),
		.rsp_valid(rsp_valid),
		.cs_n(cs_n)
	);

	// Byte shifter with pin stage
	spi_shifter shifter0 (
		.apb(apb),
		.reset(reset),
		.shift_req(shift_req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.shift_rsp(shift_rsp),
		.rsp_valid(rsp_valid),
		.cs_n(cs_n),
		.spi_sck(spi_sck),
		.spi_mosi(spi_mosi),
		.spi_miso(spi_miso),
		.spi_cs_n(spi_cs_n)
	);

endmodule

// ==== verilog/spi_shifter.sv ====
`timescale 1ns/10ps
`include "spi_host_cfg.svh"

module spi_shifter (
	input logic apb,
	input logic reset,

	// Transfer request
	input spi_host_pkg::shift_req_t shift_req,
	input logic req_valid,
	output logic req_ready,

	// Received byte
	output spi_host_pkg::shift_rsp_t shift_rsp,
	output logic rsp_valid,

	// Chip select level from the register block
	input logic cs_n,

	// SPI pins
	output logic spi_sck,
	output logic spi_mosi,
	input logic spi_miso,
	output logic spi_cs_n
);

	////////////////////////////////////////
	// Transfer state

	logic active;
	logic [`SPI_APB_WIDTH-1:0] div_lat;
	logic [`SPI_APB_WIDTH-1:0] div_cnt;
	// Half periods done, 0..16
	logic [4:0] half_cnt;
	logic [7:0] tx_sr;
	logic [7:0] rx_sr;

	logic accept;
	logic running;
	logic toggle;

	// Idle whenever no byte is in flight
	assign req_ready = !active;
	assign accept = req_valid && req_ready;

	// Counting stops once all 16 half periods are out
	assign running = active && (half_cnt != 5'd16);

	// End of one half period
	assign toggle = running && (div_cnt == div_lat - 1'b1);

	assign shift_rsp.rx_data = rx_sr;

	////////////////////////////////////////
	// Byte engine

	always_ff @(posedge apb) begin
		if (reset) begin
			active <= 1'b0;
			div_cnt <= '0;
			half_cnt <= 5'd0;
			rsp_valid <= 1'b0;
			spi_sck <= 1'b0;
			spi_mosi <= 1'b0;
		end else begin
			rsp_valid <= 1'b0;

			if (accept) begin
				active <= 1'b1;
				div_cnt <= '0;
				half_cnt <= 5'd0;
				// MSB goes out right away
				spi_mosi <= shift_req.tx_data[7];
			end else if (toggle) begin
				div_cnt <= '0;
				half_cnt <= half_cnt + 5'd1;
				spi_sck <= !spi_sck;

				// Falling SCK, next bit on MOSI
				if (spi_sck)
					spi_mosi <= tx_sr[6];

				// Last falling edge ends the byte
				if (half_cnt == 5'd15)
					rsp_valid <= 1'b1;
			end else if (running) begin
				div_cnt <= div_cnt + 1'b1;
			end

			// Ready again the cycle after the response
			if (rsp_valid)
				active <= 1'b0;
		end
	end

	// Data path, no reset needed
	always_ff @(posedge apb) begin
		if (accept) begin
			div_lat <= shift_req.clk_div;
			tx_sr <= shift_req.tx_data;
		end else if (toggle) begin
			if (spi_sck)
				tx_sr <= {tx_sr[6:0], 1'b0};
			else
				// Rising SCK samples MISO
				rx_sr <= {rx_sr[6:0], spi_miso};
		end
	end

	////////////////////////////////////////
	// Chip select pin

	// One cycle behind the register value
	always_ff @(posedge apb) begin
		if (reset)
			spi_cs_n <= 1'b1;
		else
			spi_cs_n <= cs_n;
	end

	////////////////////////////////////////
	// Checks

	a_half_cnt_range: assert property (
		@(posedge apb) disable iff (reset)
		half_cnt <= 5'd16
	) else $error("half period counter out of range");

	// Idle means SCK parked low, as mode 0 wants
	a_sck_idle_low: assert property (
		@(posedge apb) disable iff (reset)
		req_ready |-> !spi_sck
	) else $error("SCK high while shifter idle");

endmodule

// ==== verilog/apb_spi_regs.sv ====
`timescale 1ns/10ps
`include "spi_host_cfg.svh"

module apb_spi_regs (
	input logic apb,
	input logic reset,

	// APB completer port
	input spi_host_pkg::apb_req_t apb_req,
	output spi_host_pkg::apb_rsp_t apb_rsp,

	// Transfer request toward the shifter
	output spi_host_pkg::shift_req_t shift_req,
	output logic req_valid,
	input logic req_ready,

	// Received byte back from the shifter
	input spi_host_pkg::shift_rsp_t shift_rsp,
	input logic rsp_valid,

	// Chip select level as programmed
	output logic cs_n
);

	////////////////////////////////////////
	// Register state

	logic [`SPI_APB_WIDTH-1:0] clk_div;
	logic cs_reg;
	logic busy;
	logic [7:0] rx_byte;

	////////////////////////////////////////
	// Access decode

	logic access;
	logic data_wr;
	logic err;
	logic wr_en;
	logic [`SPI_APB_WIDTH-1:0] rdata;

	always_comb begin
		// Access phase of any transfer
		access = apb_req.psel && apb_req.penable;

		// DATA write, the only access that can stall
		data_wr = apb_req.pwrite && (apb_req.paddr == `SPI_REG_DATA);

		// Error and read mux
		err = 1'b0;
		rdata = '0;
		case (apb_req.paddr)
			`SPI_REG_CLK_DIV: begin
				// Zero divider would stall SCK forever
				if (apb_req.pwrite && (apb_req.pwdata == '0))
					err = 1'b1;
				rdata = clk_div;
			end
			`SPI_REG_DATA: begin
				rdata = {{(`SPI_APB_WIDTH-8){1'b0}}, rx_byte};
			end
			`SPI_REG_CS_N: begin
				rdata = {{(`SPI_APB_WIDTH-1){1'b0}}, cs_reg};
			end
			`SPI_REG_STATUS: begin
				// Read only
				if (apb_req.pwrite)
					err = 1'b1;
				rdata = {{(`SPI_APB_WIDTH-1){1'b0}}, busy};
			end
			default: begin
				// Unmapped
				err = 1'b1;
			end
		endcase

		// Wait states only for a DATA write while a transfer runs
		apb_rsp.pready = access && (!data_wr || req_ready);

		apb_rsp.pslverr = access && err;

		// Read data only on a clean read, zero otherwise
		if (access && !apb_req.pwrite && !err)
			apb_rsp.prdata = rdata;
		else
			apb_rsp.prdata = '0;

		// Write takes effect in the completing cycle
		wr_en = apb_rsp.pready && apb_req.pwrite && !err;
	end

	////////////////////////////////////////
	// Shift request

	// Fires in the completing cycle of a DATA write only
	assign req_valid = wr_en && data_wr;

	assign shift_req.tx_data = apb_req.pwdata[7:0];
	assign shift_req.clk_div = clk_div;

	assign cs_n = cs_reg;

	////////////////////////////////////////
	// Register updates

	always_ff @(posedge apb) begin
		if (reset) begin
			clk_div <= `SPI_CLK_DIV_RESET;
			// Deselected out of reset
			cs_reg <= 1'b1;
			busy <= 1'b0;
			rx_byte <= 8'h00;
		end else begin
			if (wr_en && (apb_req.paddr == `SPI_REG_CLK_DIV))
				clk_div <= apb_req.pwdata;
			if (wr_en && (apb_req.paddr == `SPI_REG_CS_N))
				cs_reg <= apb_req.pwdata[0];

			// Transfer done, keep the byte
			if (rsp_valid) begin
				busy <= 1'b0;
				rx_byte <= shift_rsp.rx_data;
			end

			// New transfer accepted
			if (req_valid)
				busy <= 1'b1;
		end
	end

	////////////////////////////////////////
	// Handshake checks

	// Request only offered when the shifter can take it
	a_valid_needs_ready: assert property (
		@(posedge apb) disable iff (reset)
		req_valid |-> req_ready
	) else $error("req_valid raised while shifter not ready");

	// Shifter reports only transfers this block started
	a_rsp_while_busy: assert property (
		@(posedge apb) disable iff (reset)
		rsp_valid |-> busy
	) else $error("rsp_valid arrived with busy low");

endmodule

// ==== verilog/spi_host_pkg.sv ====
`include "spi_host_cfg.svh"

package spi_host_pkg;

	////////////////////////////////////////
	// APB side

	// Requester to completer
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [7:0] paddr;
		logic [`SPI_APB_WIDTH-1:0] pwdata;
	} apb_req_t;

	// Completer back to requester
	typedef struct packed {
		logic pready;
		logic pslverr;
		logic [`SPI_APB_WIDTH-1:0] prdata;
	} apb_rsp_t;

	////////////////////////////////////////
	// Register block to shifter

	// One byte to send plus the divider in force for it
	typedef struct packed {
		logic [7:0] tx_data;
		logic [`SPI_APB_WIDTH-1:0] clk_div;
	} shift_req_t;

	// Byte captured from MISO
	typedef struct packed {
		logic [7:0] rx_data;
	} shift_rsp_t;

endpackage

// ==== include/spi_host_cfg.svh ====
`ifndef SPI_HOST_CFG_SVH
`define SPI_HOST_CFG_SVH

////////////////////////////////////////
// Register map, byte addresses

// SCK half period in apb cycles
`define SPI_REG_CLK_DIV 8'h00
// Write starts a transfer, read gives last rx byte
`define SPI_REG_DATA 8'h02
// Chip select level in bit 0
`define SPI_REG_CS_N 8'h04
// Busy flag in bit 0, read only
`define SPI_REG_STATUS 8'h20

////////////////////////////////////////
// Widths and reset values

`define SPI_CLK_DIV_RESET 16'd100
`define SPI_APB_WIDTH 16

`endif
